// ==== Makefile ====
TOP := dcache_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== filelist.f ====
src/dcache_pkg.sv
src/dcache_way_mem.sv
src/dcache_hit_select.sv
src/dcache_ctrl.sv
src/dcache_top.sv
testbench/tb_clk_gen.sv
testbench/dcache_props.sv
testbench/dcache_tb.sv

// ==== src/dcache_ctrl.sv ====
// cache controller FSM with request register, LRU bits, refill counter and array writes
`timescale 1ns/10ps

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    // cpu side
    input  logic               cpu_req_valid_i,
    input  cpu_req_t           cpu_req_i,
    output logic               cpu_req_ready_o,
    output logic               cpu_rsp_valid_o,
    input  logic               cpu_rsp_ready_i,
    output logic [DATA_W-1:0]  cpu_rdata_o,
    // memory side
    output logic               mem_req_valid_o,
    input  logic               mem_req_ready_i,
    output mem_req_t           mem_req_o,
    input  logic               mem_rdata_valid_i,
    input  logic [DATA_W-1:0]  mem_rdata_i,
    // arrays
    output logic [INDEX_W-1:0] rd_index_o,
    output way_wr_t            way0_wr_o,
    output way_wr_t            way1_wr_o,
    // hit selector
    output cpu_req_t           req_o,
    output logic               lru_o,
    input  logic               hit_i,
    input  logic               hit_way_i,
    input  logic [DATA_W-1:0]  rdata_i,
    input  logic               victim_way_i,
    input  logic               writeback_i,
    input  line_t              victim_line_i,
    input  logic [ADDR_W-1:0]  victim_addr_i
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD,
        S_LOOKUP,
        S_WB,
        S_RF_REQ,
        S_REFILL,
        S_REREAD,
        S_RESP
    } state_t;

    state_t                state_q;
    state_t                state_d;
    cpu_req_t              req_q;
    logic [DATA_W-1:0]     rdata_q;
    mem_req_t              mem_req_q;
    logic                  victim_q;   // way being refilled
    logic [WORD_SEL_W-1:0] beat_q;
    logic [NUM_SETS-1:0]   lru_q;
    logic                  last_beat;
    logic [ADDR_W-1:0]     line_base;
    way_wr_t               wr_cmd;
    logic [NUM_WAYS-1:0]   wr_sel;

    assign last_beat = mem_rdata_valid_i && (beat_q == WORD_SEL_W'(WORDS_PER_LINE - 1));
    assign line_base = {req_q.addr.tag, req_q.addr.index, {OFFSET_W{1'b0}}};

    // --------------------------------------------------
    // next state
    // --------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (cpu_req_valid_i) begin
                    state_d = S_RD;
                end
            end
            S_RD, S_REREAD: begin
                state_d = S_LOOKUP;
            end
            S_LOOKUP: begin
                if (hit_i) begin
                    state_d = S_RESP;
                end else if (writeback_i) begin
                    state_d = S_WB;
                end else begin
                    state_d = S_RF_REQ;
                end
            end
            S_WB: begin
                if (mem_req_ready_i) begin
                    state_d = S_RF_REQ;
                end
            end
            S_RF_REQ: begin
                if (mem_req_ready_i) begin
                    state_d = S_REFILL;
                end
            end
            S_REFILL: begin
                if (last_beat) begin
                    state_d = S_REREAD;  // look up again, now a hit
                end
            end
            S_RESP: begin
                if (cpu_rsp_ready_i) begin
                    state_d = S_IDLE;
                end
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= S_IDLE;
            victim_q <= 1'b0;
            beat_q   <= '0;
            lru_q    <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == S_LOOKUP && !hit_i) begin
                victim_q <= victim_way_i;
            end
            if (state_q == S_REFILL && mem_rdata_valid_i) begin
                beat_q <= beat_q + 1'b1;  // wraps after the fourth beat
            end
            // lru points at the way not just used
            if (state_q == S_LOOKUP && hit_i) begin
                lru_q[req_q.addr.index] <= ~hit_way_i;
            end else if (state_q == S_REFILL && last_beat) begin
                lru_q[req_q.addr.index] <= ~victim_q;
            end
        end
    end

    // --------------------------------------------------
    // request, response and memory request registers
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (cpu_req_valid_i && cpu_req_ready_o) begin
            req_q <= cpu_req_i;
        end
        if (state_q == S_LOOKUP && hit_i) begin
            rdata_q <= rdata_i;
        end
        if (state_q == S_LOOKUP && !hit_i) begin
            mem_req_q.write <= writeback_i;
            mem_req_q.addr  <= writeback_i ? victim_addr_i : line_base;
            mem_req_q.wdata <= victim_line_i;
        end else if (state_q == S_WB && mem_req_ready_i) begin
            mem_req_q.write <= 1'b0;       // write-back taken, refill read next
            mem_req_q.addr  <= line_base;
        end
    end

    // --------------------------------------------------
    // array write commands
    // --------------------------------------------------
    always_comb begin
        wr_cmd       = '0;
        wr_cmd.index = req_q.addr.index;
        wr_cmd.tag   = req_q.addr.tag;
        wr_cmd.valid = 1'b1;
        wr_sel       = '0;
        if (state_q == S_LOOKUP && hit_i && req_q.write) begin
            wr_cmd.word       = req_q.addr.offset[OFFSET_W-1 -: WORD_SEL_W];
            wr_cmd.data_be    = req_q.strb;
            wr_cmd.data       = req_q.wdata;
            wr_cmd.meta_we    = 1'b1;
            wr_cmd.dirty      = 1'b1;  // store hit dirties the line
            wr_sel[hit_way_i] = 1'b1;
        end else if (state_q == S_REFILL && mem_rdata_valid_i) begin
            wr_cmd.word      = beat_q;
            wr_cmd.data_be   = '1;
            wr_cmd.data      = mem_rdata_i;
            wr_cmd.meta_we   = last_beat;  // tag goes in with the last word, clean
            wr_sel[victim_q] = 1'b1;
        end
    end

    function automatic way_wr_t gate_wr(way_wr_t cmd, logic en);
        way_wr_t g;
        g = cmd;
        if (!en) begin
            g.data_be = '0;
            g.meta_we = 1'b0;
        end
        return g;
    endfunction

    assign way0_wr_o = gate_wr(wr_cmd, wr_sel[0]);
    assign way1_wr_o = gate_wr(wr_cmd, wr_sel[1]);

    // outputs
    assign cpu_req_ready_o = (state_q == S_IDLE);
    assign cpu_rsp_valid_o = (state_q == S_RESP);
    assign cpu_rdata_o     = rdata_q;
    assign mem_req_valid_o = (state_q == S_WB) || (state_q == S_RF_REQ);
    assign mem_req_o       = mem_req_q;
    assign rd_index_o      = req_q.addr.index;
    assign req_o           = req_q;
    assign lru_o           = lru_q[req_q.addr.index];

endmodule

// ==== src/dcache_hit_select.sv ====
// hit detection, word select, store merge and victim choice for the two ways
`timescale 1ns/10ps

module dcache_hit_select
    import dcache_pkg::*;
(
    input  cpu_req_t           req_i,
    input  way_rd_t            way0_i,
    input  way_rd_t            way1_i,
    input  logic               lru_i,
    output logic               hit_o,
    output logic               hit_way_o,
    output logic [DATA_W-1:0]  rdata_o,
    output logic               victim_way_o,
    output logic               writeback_o,
    output line_t              victim_line_o,
    output logic [ADDR_W-1:0]  victim_addr_o
);

    logic        hit0;
    logic        hit1;
    line_t       hit_line;
    logic [DATA_W-1:0] word;
    way_rd_t     victim;
    cache_addr_t vaddr;

    // --------------------------------------------------
    // tag compare and word select
    // --------------------------------------------------
    assign hit0      = way0_i.valid && (way0_i.tag == req_i.addr.tag);
    assign hit1      = way1_i.valid && (way1_i.tag == req_i.addr.tag);
    assign hit_o     = hit0 || hit1;
    assign hit_way_o = hit1;

    assign hit_line = hit1 ? way1_i.line : way0_i.line;
    assign word     = hit_line[req_i.addr.offset[OFFSET_W-1 -: WORD_SEL_W]];

    // store bytes replace the old ones under the strobes
    always_comb begin
        rdata_o = word;
        if (req_i.write) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (req_i.strb[b]) begin
                    rdata_o[b*8 +: 8] = req_i.wdata[b*8 +: 8];
                end
            end
        end
    end

    // --------------------------------------------------
    // replacement
    // --------------------------------------------------
    always_comb begin
        if (!way0_i.valid) begin
            victim_way_o = 1'b0;
        end else if (!way1_i.valid) begin
            victim_way_o = 1'b1;
        end else begin
            victim_way_o = lru_i;  // both valid, follow lru
        end
    end

    assign victim        = victim_way_o ? way1_i : way0_i;
    assign writeback_o   = victim.valid && victim.dirty;
    assign victim_line_o = victim.line;

    // line base of the victim
    always_comb begin
        vaddr.tag     = victim.tag;
        vaddr.index   = req_i.addr.index;
        vaddr.offset  = '0;
        victim_addr_o = vaddr;
    end

endmodule

// ==== src/dcache_pkg.sv ====
// data cache package with geometry constants and the shared packed types
package dcache_pkg;

    // --------------------------------------------------
    // geometry
    // --------------------------------------------------
    localparam int ADDR_W         = 32;
    localparam int DATA_W         = 32;
    localparam int STRB_W         = 4;   // one strobe per byte
    localparam int WORDS_PER_LINE = 4;
    localparam int WORD_SEL_W     = 2;   // word within a line
    localparam int OFFSET_W       = 4;   // byte offset in a line
    localparam int NUM_SETS       = 16;
    localparam int INDEX_W        = 4;
    localparam int TAG_W          = 24;
    localparam int NUM_WAYS       = 2;

    // --------------------------------------------------
    // address and request types
    // --------------------------------------------------
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } cache_addr_t;

    typedef logic [WORDS_PER_LINE-1:0][DATA_W-1:0] line_t;

    typedef struct packed {
        logic              write;
        cache_addr_t       addr;
        logic [STRB_W-1:0] strb;
        logic [DATA_W-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic              write;
        logic [ADDR_W-1:0] addr;   // line base address
        line_t             wdata;  // victim line, writes only
    } mem_req_t;

    // contents of one way at one index
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic             valid;
        logic             dirty;
        line_t            line;
    } way_rd_t;

    typedef struct packed {
        logic [INDEX_W-1:0]    index;
        logic [WORD_SEL_W-1:0] word;
        logic [STRB_W-1:0]     data_be;  // byte enables for data
        logic [DATA_W-1:0]     data;
        logic                  meta_we;  // writes tag, valid and dirty
        logic [TAG_W-1:0]      tag;
        logic                  valid;
        logic                  dirty;
    } way_wr_t;

endpackage

// ==== src/dcache_top.sv ====
// two-way write-back data cache top joining controller, hit selector and ways
`timescale 1ns/10ps

module dcache_top
    import dcache_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    // cpu side
    input  logic              cpu_req_valid_i,
    output logic              cpu_req_ready_o,
    input  cpu_req_t          cpu_req_i,
    output logic              cpu_rsp_valid_o,
    input  logic              cpu_rsp_ready_i,
    output logic [DATA_W-1:0] cpu_rdata_o,
    // memory side
    output logic              mem_req_valid_o,
    input  logic              mem_req_ready_i,
    output mem_req_t          mem_req_o,
    input  logic              mem_rdata_valid_i,
    input  logic [DATA_W-1:0] mem_rdata_i
);

    logic [INDEX_W-1:0] rd_index;
    way_wr_t            way0_wr;
    way_wr_t            way1_wr;
    way_rd_t            way0_rd;
    way_rd_t            way1_rd;
    cpu_req_t           req;
    logic               lru;
    logic               hit;
    logic               hit_way;
    logic [DATA_W-1:0]  rdata;
    logic               victim_way;
    logic               writeback;
    line_t              victim_line;
    logic [ADDR_W-1:0]  victim_addr;

    dcache_ctrl ctrl_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .cpu_req_valid_i   (cpu_req_valid_i),
        .cpu_req_i         (cpu_req_i),
        .cpu_req_ready_o   (cpu_req_ready_o),
        .cpu_rsp_valid_o   (cpu_rsp_valid_o),
        .cpu_rsp_ready_i   (cpu_rsp_ready_i),
        .cpu_rdata_o       (cpu_rdata_o),
        .mem_req_valid_o   (mem_req_valid_o),
        .mem_req_ready_i   (mem_req_ready_i),
        .mem_req_o         (mem_req_o),
        .mem_rdata_valid_i (mem_rdata_valid_i),
        .mem_rdata_i       (mem_rdata_i),
        .rd_index_o        (rd_index),
        .way0_wr_o         (way0_wr),
        .way1_wr_o         (way1_wr),
        .req_o             (req),
        .lru_o             (lru),
        .hit_i             (hit),
        .hit_way_i         (hit_way),
        .rdata_i           (rdata),
        .victim_way_i      (victim_way),
        .writeback_i       (writeback),
        .victim_line_i     (victim_line),
        .victim_addr_i     (victim_addr)
    );

    dcache_hit_select hit_sel_i (
        .req_i         (req),
        .way0_i        (way0_rd),
        .way1_i        (way1_rd),
        .lru_i         (lru),
        .hit_o         (hit),
        .hit_way_o     (hit_way),
        .rdata_o       (rdata),
        .victim_way_o  (victim_way),
        .writeback_o   (writeback),
        .victim_line_o (victim_line),
        .victim_addr_o (victim_addr)
    );

    // both ways share the read index
    dcache_way_mem way0_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_index_i (rd_index),
        .wr_i       (way0_wr),
        .rd_o       (way0_rd)
    );

    dcache_way_mem way1_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_index_i (rd_index),
        .wr_i       (way1_wr),
        .rd_o       (way1_rd)
    );

endmodule

// ==== src/dcache_way_mem.sv ====
// cache way storage holding tag, valid, dirty and data arrays with a registered read
`timescale 1ns/10ps

module dcache_way_mem
    import dcache_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic [INDEX_W-1:0] rd_index_i,
    input  way_wr_t            wr_i,
    output way_rd_t            rd_o
);

    logic [TAG_W-1:0]    tag_mem [NUM_SETS];
    line_t               data_mem [NUM_SETS];
    logic [NUM_SETS-1:0] dirty_mem;
    logic [NUM_SETS-1:0] valid_q;

    // --------------------------------------------------
    // valid bits, cleared at reset
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (wr_i.meta_we) begin
            valid_q[wr_i.index] <= wr_i.valid;
        end
    end

    // --------------------------------------------------
    // tag, dirty and data arrays
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr_i.meta_we) begin
            tag_mem[wr_i.index]   <= wr_i.tag;
            dirty_mem[wr_i.index] <= wr_i.dirty;
        end
        // byte lanes of the selected word
        for (int b = 0; b < STRB_W; b++) begin
            if (wr_i.data_be[b]) begin
                data_mem[wr_i.index][wr_i.word][b*8 +: 8] <= wr_i.data[b*8 +: 8];
            end
        end
    end

    // full way read, one cycle after the index
    always_ff @(posedge clk) begin
        rd_o.tag   <= tag_mem[rd_index_i];
        rd_o.valid <= valid_q[rd_index_i];
        rd_o.dirty <= dirty_mem[rd_index_i];
        rd_o.line  <= data_mem[rd_index_i];  // old contents if written this edge
    end

endmodule

// ==== testbench/dcache_props.sv ====
// handshake and reset assertions for the data cache top level
`timescale 1ns/10ps

module dcache_props
    import dcache_pkg::*;
(
    input logic              clk,
    input logic              rst_n,
    input logic              req_ready_i,
    input logic              rsp_valid_i,
    input logic              rsp_ready_i,
    input logic [DATA_W-1:0] rdata_i,
    input logic              mem_valid_i,
    input logic              mem_ready_i,
    input mem_req_t          mem_req_i
);

    int unsigned fail_count = 0;

    // idle outputs on the first edge out of reset
    reset_values: assert property (@(posedge clk)
        $rose(rst_n) |-> req_ready_i && !rsp_valid_i && !mem_valid_i)
        else begin
            fail_count++;
            $error("outputs not idle after reset");
        end

    rsp_held: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rdata_i))
        else begin
            fail_count++;
            $error("response changed before handshake");
        end

    mem_held: assert property (@(posedge clk) disable iff (!rst_n)
        mem_valid_i && !mem_ready_i |=> mem_valid_i && $stable(mem_req_i))
        else begin
            fail_count++;
            $error("memory request changed before accept");
        end

    // one request in flight
    no_accept_in_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid_i |-> !req_ready_i)
        else begin
            fail_count++;
            $error("request ready while response pending");
        end

endmodule

bind dcache_top dcache_props props_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_ready_i (cpu_req_ready_o),
    .rsp_valid_i (cpu_rsp_valid_o),
    .rsp_ready_i (cpu_rsp_ready_i),
    .rdata_i     (cpu_rdata_o),
    .mem_valid_i (mem_req_valid_o),
    .mem_ready_i (mem_req_ready_i),
    .mem_req_i   (mem_req_o)
);

// ==== testbench/dcache_tb.sv ====
// data cache testbench with a stimulus table, memory model and shadow copy of memory
`timescale 1ns/10ps

module dcache_tb
    import dcache_pkg::*;
();

    localparam int          RESET_CYCLES      = 8;
    localparam int          CYCLES_PER_ACCESS = 60;
    localparam int          NUM_ENTRIES       = 21;
    localparam int          NUM_LINES         = 7;
    localparam int          NUM_ACCESSES      = NUM_ENTRIES + NUM_LINES * WORDS_PER_LINE;
    localparam int          TIMEOUT_CYCLES    = NUM_ACCESSES * CYCLES_PER_ACCESS + RESET_CYCLES;
    localparam int unsigned SEED              = 32'h8d71;
    localparam logic        LD                = 1'b0;
    localparam logic        ST                = 1'b1;

    // lines read back at the end
    localparam logic [ADDR_W-1:0] LINE_BASES [NUM_LINES] = '{
        32'h0000_1020, 32'h1000_0040, 32'h2000_0040, 32'h3000_0040,
        32'h0000_2020, 32'h0000_3020, 32'h0000_4020
    };

    typedef struct packed {
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [STRB_W-1:0] strb;
        logic [DATA_W-1:0] wdata;
        logic              refill;   // refill read expected
        logic              wb;       // write-back expected
        logic [ADDR_W-1:0] wb_addr;
    } entry_t;

    logic              clk;
    logic              rst_n;
    logic              cpu_req_valid;
    logic              cpu_req_ready;
    cpu_req_t          cpu_req;
    logic              cpu_rsp_valid;
    logic              cpu_rsp_ready;
    logic [DATA_W-1:0] cpu_rdata;
    logic              mem_req_valid;
    logic              mem_req_ready;
    mem_req_t          mem_req;
    logic              mem_rdata_valid;
    logic [DATA_W-1:0] mem_rdata;

    entry_t            stim_table [NUM_ENTRIES];
    logic [DATA_W-1:0] mem_words [logic [ADDR_W-1:0]];  // memory model holding written words
    logic [DATA_W-1:0] shadow [logic [ADDR_W-1:0]];     // expected contents
    logic [ADDR_W-1:0] refill_addrs [$];
    logic [ADDR_W-1:0] wb_addrs [$];
    int                check_errors = 0;
    int                other_errors = 0;
    int                cycle_cnt;

    tb_clk_gen clk_gen_i (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    dcache_top dut_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .cpu_req_valid_i   (cpu_req_valid),
        .cpu_req_ready_o   (cpu_req_ready),
        .cpu_req_i         (cpu_req),
        .cpu_rsp_valid_o   (cpu_rsp_valid),
        .cpu_rsp_ready_i   (cpu_rsp_ready),
        .cpu_rdata_o       (cpu_rdata),
        .mem_req_valid_o   (mem_req_valid),
        .mem_req_ready_i   (mem_req_ready),
        .mem_req_o         (mem_req),
        .mem_rdata_valid_i (mem_rdata_valid),
        .mem_rdata_i       (mem_rdata)
    );

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    function automatic logic [DATA_W-1:0] init_word(input logic [ADDR_W-1:0] addr);
        return {addr[15:0], addr[31:16]} ^ (addr * 32'h9e37_79b1) ^ 32'h5a0f_c3a5;
    endfunction

    function automatic logic [DATA_W-1:0] mem_read(input logic [ADDR_W-1:0] addr);
        if (mem_words.exists(addr)) begin
            return mem_words[addr];
        end
        return init_word(addr);
    endfunction

    function automatic logic [DATA_W-1:0] shadow_read(input logic [ADDR_W-1:0] addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        return init_word(addr);
    endfunction

    // strobed bytes come from the store and the rest stay
    function automatic logic [DATA_W-1:0] merge_bytes(
        input logic [DATA_W-1:0] old_word,
        input logic [DATA_W-1:0] wdata,
        input logic [STRB_W-1:0] strb
    );
        logic [DATA_W-1:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_word & ~mask) | (wdata & mask);
    endfunction

    task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        other_errors++;
        $display("ERROR: %s", msg);
    endtask

    // op, address, strobes, write data, refill, write-back, write-back address
    task automatic fill_table();
        stim_table[0]  = '{LD, 32'h0000_1020, 4'b0000, 32'h0000_0000, 1'b1, 1'b0, 32'h0};
        stim_table[1]  = '{LD, 32'h0000_102c, 4'b0000, 32'h0000_0000, 1'b0, 1'b0, 32'h0};
        stim_table[2]  = '{ST, 32'h0000_1024, 4'b0101, 32'hdead_beef, 1'b0, 1'b0, 32'h0};
        stim_table[3]  = '{LD, 32'h0000_1024, 4'b0000, 32'h0000_0000, 1'b0, 1'b0, 32'h0};
        stim_table[4]  = '{ST, 32'h0000_1028, 4'b1111, 32'h1234_5678, 1'b0, 1'b0, 32'h0};
        // three tags in set 4
        stim_table[5]  = '{LD, 32'h1000_0040, 4'b0000, 32'h0000_0000, 1'b1, 1'b0, 32'h0};
        stim_table[6]  = '{ST, 32'h2000_0044, 4'b0011, 32'hcafe_f00d, 1'b1, 1'b0, 32'h0};
        stim_table[7]  = '{LD, 32'h3000_0048, 4'b0000, 32'h0000_0000, 1'b1, 1'b0, 32'h0};
        stim_table[8]  = '{LD, 32'h1000_0040, 4'b0000, 32'h0, 1'b1, 1'b1, 32'h2000_0040};
        stim_table[9]  = '{LD, 32'h2000_0044, 4'b0000, 32'h0000_0000, 1'b1, 1'b0, 32'h0};
        stim_table[10] = '{ST, 32'h3000_0040, 4'b1000, 32'hab00_0000, 1'b1, 1'b0, 32'h0};
        stim_table[11] = '{LD, 32'h1000_0040, 4'b0000, 32'h0000_0000, 1'b1, 1'b0, 32'h0};
        stim_table[12] = '{LD, 32'h2000_0048, 4'b0000, 32'h0, 1'b1, 1'b1, 32'h3000_0040};
        // set 2 again so the dirty line goes out
        stim_table[13] = '{ST, 32'h0000_2020, 4'b1111, 32'h0bad_cafe, 1'b1, 1'b0, 32'h0};
        stim_table[14] = '{LD, 32'h0000_3028, 4'b0000, 32'h0, 1'b1, 1'b1, 32'h0000_1020};
        stim_table[15] = '{LD, 32'h0000_4020, 4'b0000, 32'h0, 1'b1, 1'b1, 32'h0000_2020};
        stim_table[16] = '{LD, 32'h0000_1024, 4'b0000, 32'h0000_0000, 1'b1, 1'b0, 32'h0};
        stim_table[17] = '{ST, 32'h0000_1020, 4'b0010, 32'h0000_7700, 1'b0, 1'b0, 32'h0};
        stim_table[18] = '{LD, 32'h0000_1020, 4'b0000, 32'h0000_0000, 1'b0, 1'b0, 32'h0};
        stim_table[19] = '{LD, 32'h0000_402c, 4'b0000, 32'h0000_0000, 1'b0, 1'b0, 32'h0};
        stim_table[20] = '{LD, 32'h0000_2024, 4'b0000, 32'h0, 1'b1, 1'b1, 32'h0000_1020};
    endtask

    // --------------------------------------------------
    // one cpu access, request to response handshake
    // --------------------------------------------------
    task automatic run_access(input entry_t e, input logic check_mem);
        cpu_req_t          req;
        logic [ADDR_W-1:0] waddr;
        logic [ADDR_W-1:0] base;
        logic [DATA_W-1:0] exp_data;
        logic              accepted;
        int                stall;

        waddr    = {e.addr[ADDR_W-1:2], 2'b00};
        base     = {e.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        exp_data = shadow_read(waddr);
        if (e.write) begin
            exp_data      = merge_bytes(exp_data, e.wdata, e.strb);
            shadow[waddr] = exp_data;
        end
        refill_addrs.delete();
        wb_addrs.delete();

        req.write     = e.write;
        req.addr      = e.addr;
        req.strb      = e.strb;
        req.wdata     = e.wdata;
        cpu_req       = req;
        cpu_req_valid = 1'b1;
        do begin
            @(negedge clk);
            accepted = cpu_req_ready;
            @(posedge clk);
            #2;
        end while (!accepted);
        cpu_req_valid = 1'b0;

        do begin
            @(negedge clk);
        end while (!cpu_rsp_valid);
        stall = $urandom_range(0, 3);
        repeat (stall) @(posedge clk);
        @(posedge clk);
        #2;
        cpu_rsp_ready = 1'b1;
        @(negedge clk);
        if (!cpu_rsp_valid) begin
            report_error($sformatf("response for %h dropped before the handshake", e.addr));
        end
        check_value("cpu_rdata_o", cpu_rdata, exp_data);
        @(posedge clk);
        #2;
        cpu_rsp_ready = 1'b0;

        if (check_mem) begin
            if (refill_addrs.size() != (e.refill ? 1 : 0)) begin
                report_error($sformatf("access to %h made %0d refill reads, expected %0d",
                                       e.addr, refill_addrs.size(), e.refill));
            end else if (e.refill) begin
                check_value("mem_req_o.addr", refill_addrs[0], base);
            end
            if (wb_addrs.size() != (e.wb ? 1 : 0)) begin
                report_error($sformatf("access to %h made %0d write-backs, expected %0d",
                                       e.addr, wb_addrs.size(), e.wb));
            end else if (e.wb) begin
                check_value("mem_req_o.addr", wb_addrs[0], e.wb_addr);
            end
        end
    endtask

    // --------------------------------------------------
    // memory model with random ready stalls and beat gaps
    // --------------------------------------------------
    initial begin : memory_model
        mem_req_t          req;
        logic [ADDR_W-1:0] waddr;
        int                gap;

        mem_req_ready   = 1'b0;
        mem_rdata_valid = 1'b0;
        mem_rdata       = '0;
        wait (rst_n === 1'b1);
        @(posedge clk);
        #2;
        forever begin
            mem_req_ready = ($urandom_range(0, 3) != 0);
            @(negedge clk);
            if (mem_req_valid && mem_req_ready) begin
                req = mem_req;
                @(posedge clk);
                #2;
                mem_req_ready = 1'b0;
                if (req.addr[OFFSET_W-1:0] != '0) begin
                    report_error($sformatf("memory request address %h not line aligned",
                                           req.addr));
                end
                if (req.write) begin
                    for (int w = 0; w < WORDS_PER_LINE; w++) begin
                        waddr = req.addr + 32'(w * 4);
                        check_value($sformatf("mem_req_o.wdata[%0d]", w), req.wdata[w],
                                    shadow_read(waddr));
                        mem_words[waddr] = req.wdata[w];
                    end
                    wb_addrs.push_back(req.addr);
                end else begin
                    refill_addrs.push_back(req.addr);
                    for (int w = 0; w < WORDS_PER_LINE; w++) begin
                        gap = $urandom_range(0, 2);
                        repeat (gap) begin
                            @(posedge clk);
                            #2;
                        end
                        mem_rdata_valid = 1'b1;
                        mem_rdata       = mem_read(req.addr + 32'(w * 4));
                        @(posedge clk);
                        #2;
                        mem_rdata_valid = 1'b0;
                    end
                end
            end else begin
                @(posedge clk);
                #2;
            end
        end
    end

    // run limit
    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        report_error($sformatf("timeout, run did not finish within %0d cycles",
                               TIMEOUT_CYCLES));
        $display("errors: %0d value mismatches, %0d other failures, %0d assertion failures",
                 check_errors, other_errors, int'(dut_i.props_i.fail_count));
        $display("Testbench failed");
        $finish;
    end

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin : main_seq
        entry_t e;
        int     assert_errors;

        void'($urandom(SEED));
        cpu_req_valid = 1'b0;
        cpu_req       = '0;
        cpu_rsp_ready = 1'b0;
        fill_table();

        wait (rst_n === 1'b1);
        @(negedge clk);
        check_value("cpu_req_ready_o", 32'(cpu_req_ready), 32'h1);
        check_value("cpu_rsp_valid_o", 32'(cpu_rsp_valid), 32'h0);
        check_value("mem_req_valid_o", 32'(mem_req_valid), 32'h0);
        @(posedge clk);
        #2;

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            run_access(stim_table[i], 1'b1);
        end

        // every word of every touched line against the shadow copy
        for (int l = 0; l < NUM_LINES; l++) begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                e      = '0;
                e.addr = LINE_BASES[l] + 32'(w * 4);
                run_access(e, 1'b0);
            end
        end

        assert_errors = int'(dut_i.props_i.fail_count);
        $display("errors: %0d value mismatches, %0d other failures, %0d assertion failures",
                 check_errors, other_errors, assert_errors);
        if (check_errors == 0 && other_errors == 0 && assert_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== testbench/tb_clk_gen.sv ====
// clock and reset generator for the data cache testbench
`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int RESET_CYCLES = 8;

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;  // 20 ns period
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2;
        rst_n_o = 1'b1;  // released just after an edge
    end

endmodule
